// File: logic/addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module addr_gen #(
    parameter int MEM_WORDS = 64
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   in_valid,
    input  wire rrag_mem_pkg::rrag_uop_t in_uop,
    output logic                        agu_valid,
    output rrag_mem_pkg::mem_uop_t      agu_uop
);

    localparam logic [29:0] WORD_LIMIT = 30'(MEM_WORDS);

    logic [31:0] scaled_index;
    logic [31:0] addr_start;
    logic [31:0] addr_end;
    logic        crosses_word;
    logic        out_of_range;
    logic        fault;

    always_comb begin
        scaled_index = in_uop.index << in_uop.scale;
        addr_start   = in_uop.base + scaled_index + in_uop.disp;
        addr_end     = addr_start + {29'd0, rrag_mem_pkg::size_bytes(in_uop.opsize)} - 32'd1;
        // the access must stay inside one 32-bit word of the data memory.
        crosses_word = addr_start[31:2] != addr_end[31:2];
        out_of_range = addr_start[31:2] >= WORD_LIMIT;
        fault        = (in_uop.op != rrag_mem_pkg::op_none) && (crosses_word || out_of_range);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            agu_valid <= 1'b0;
        end else begin
            agu_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            agu_uop.eip          <= in_uop.eip;
            agu_uop.op           <= in_uop.op;
            agu_uop.opsize       <= in_uop.opsize;
            agu_uop.reg_val      <= in_uop.reg_val;
            agu_uop.mem_addr     <= addr_start;
            agu_uop.mem_addr_end <= addr_end;
            agu_uop.fault        <= fault;
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
    parameter int MEM_WORDS   = 64,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   q_valid,
    input  wire rrag_mem_pkg::mem_uop_t q_uop,
    input  wire logic                   out_credit,
    output logic                        q_take,
    output logic                        out_valid,
    output rrag_mem_pkg::mem_result_t   out_result
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    logic [31:0] mem [MEM_WORDS];

    logic [CRD_W-1:0] credits;
    logic [IDX_W-1:0] word_idx;
    logic [4:0]       lane_shift;
    logic [31:0]      rd_word;
    logic [31:0]      shifted;
    logic [31:0]      load_data;
    logic [31:0]      wr_data;
    logic [31:0]      store_word;
    logic [3:0]       size_mask;
    logic [3:0]       byte_en;
    logic             do_store;

    assign q_take   = q_valid && (credits != '0);
    assign word_idx = q_uop.mem_addr[IDX_W+1:2];
    assign do_store = q_take && (q_uop.op == rrag_mem_pkg::op_store) && !q_uop.fault;

    always_comb begin
        rd_word    = mem[word_idx];
        lane_shift = {q_uop.mem_addr[1:0], 3'b000};
        shifted    = rd_word >> lane_shift;
        case (q_uop.opsize)
            rrag_mem_pkg::size_byte: begin
                load_data = {24'd0, shifted[7:0]};
                size_mask = 4'b0001;
            end
            rrag_mem_pkg::size_word: begin
                load_data = {16'd0, shifted[15:0]};
                size_mask = 4'b0011;
            end
            default: begin
                load_data = shifted;
                size_mask = 4'b1111;
            end
        endcase
        // little-endian lanes, so the lowest address byte sits in bits 7:0.
        byte_en    = size_mask << q_uop.mem_addr[1:0];
        wr_data    = q_uop.reg_val << lane_shift;
        store_word = rd_word;
        for (int b = 0; b < 4; b++) begin
            if (byte_en[b]) begin
                store_word[8*b +: 8] = wr_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (do_store) begin
            mem[word_idx] <= store_word;
        end
    end

    // a credit is spent when the record is taken, so out_valid always has one behind it.
    always_ff @(posedge clk) begin
        if (reset) begin
            credits   <= CRD_W'(OUT_CREDITS);
            out_valid <= 1'b0;
        end else begin
            credits   <= credits - CRD_W'(q_take) + CRD_W'(out_credit);
            out_valid <= q_take;
        end
    end

    always_ff @(posedge clk) begin
        if (q_take) begin
            out_result.eip   <= q_uop.eip;
            out_result.op    <= q_uop.op;
            out_result.fault <= q_uop.fault;
            if (q_uop.fault) begin
                out_result.data <= '0;
            end else if (q_uop.op == rrag_mem_pkg::op_load) begin
                out_result.data <= load_data;
            end else begin
                out_result.data <= q_uop.reg_val; // stores and pass-through ops.
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rrag_mem_latch.sv
`timescale 1ns/100ps
`default_nettype none

module rrag_mem_latch #(
    parameter int LATCH_DEPTH = 4
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         flush,
    input  wire logic                         agu_valid,
    input  wire rrag_mem_pkg::mem_uop_t       agu_uop,
    input  wire logic                         q_take,
    output logic                              q_valid,
    output rrag_mem_pkg::mem_uop_t            q_uop,
    output logic [$clog2(LATCH_DEPTH+1)-1:0] credit_return
);

    localparam int PTR_W = (LATCH_DEPTH > 1) ? $clog2(LATCH_DEPTH) : 1;
    localparam int CNT_W = $clog2(LATCH_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(LATCH_DEPTH - 1);

    rrag_mem_pkg::mem_uop_t slots [LATCH_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
    endfunction

    assign q_valid = count != '0;
    assign q_uop   = slots[rd_ptr];

    // a flush hands back every held slot, including one popped in the same cycle.
    assign credit_return = flush ? count : CNT_W'(q_take);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // a record arriving from addr_gen during the flush is kept.
            rd_ptr <= '0;
            wr_ptr <= agu_valid ? next_ptr('0) : '0;
            count  <= CNT_W'(agu_valid);
        end else begin
            if (agu_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (q_take) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(agu_valid) - CNT_W'(q_take);
        end
    end

    always_ff @(posedge clk) begin
        if (agu_valid) begin
            slots[flush ? '0 : wr_ptr] <= agu_uop;
        end
    end

endmodule

`default_nettype wire

// File: logic/rrag_mem_pkg.sv
`default_nettype none

package rrag_mem_pkg;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2
    } opsize_e;

    // micro-op as it leaves register read, before address generation.
    typedef struct packed {
        logic [31:0] eip;
        logic [31:0] base;
        logic [31:0] index;
        logic [1:0]  scale;    // index is shifted left by this amount.
        logic [31:0] disp;
        mem_op_e     op;
        opsize_e     opsize;
        logic [31:0] reg_val;  // store data, or the pass-through value.
    } rrag_uop_t;

    // record held in the rrag to mem latch.
    typedef struct packed {
        logic [31:0] eip;
        mem_op_e     op;
        opsize_e     opsize;
        logic [31:0] reg_val;
        logic [31:0] mem_addr;
        logic [31:0] mem_addr_end; // address of the last byte touched.
        logic        fault;
    } mem_uop_t;

    typedef struct packed {
        logic [31:0] eip;
        mem_op_e     op;
        logic [31:0] data;
        logic        fault;
    } mem_result_t;

    function automatic logic [2:0] size_bytes(opsize_e size);
        logic [2:0] n;
        case (size)
            size_byte: n = 3'd1;
            size_word: n = 3'd2;
            default:   n = 3'd4; // an unused encoding is treated as a dword.
        endcase
        return n;
    endfunction

endpackage

`default_nettype wire

// File: logic/rrag_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module rrag_mem_top #(
    parameter int LATCH_DEPTH = 4,
    parameter int MEM_WORDS   = 64,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         flush,
    input  wire logic                         in_valid,
    input  wire rrag_mem_pkg::rrag_uop_t      in_uop,
    output logic [$clog2(LATCH_DEPTH+1)-1:0] credit_return,
    input  wire logic                         out_credit,
    output logic                              out_valid,
    output rrag_mem_pkg::mem_result_t         out_result
);

    logic                   agu_valid;
    rrag_mem_pkg::mem_uop_t agu_uop;
    logic                   q_valid;
    rrag_mem_pkg::mem_uop_t q_uop;
    logic                   q_take;

    addr_gen #(.MEM_WORDS(MEM_WORDS)) addr_gen_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .agu_valid (agu_valid),
        .agu_uop   (agu_uop)
    );

    rrag_mem_latch #(.LATCH_DEPTH(LATCH_DEPTH)) latch_i (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .agu_valid     (agu_valid),
        .agu_uop       (agu_uop),
        .q_take        (q_take),
        .q_valid       (q_valid),
        .q_uop         (q_uop),
        .credit_return (credit_return)
    );

    mem_stage #(.MEM_WORDS(MEM_WORDS), .OUT_CREDITS(OUT_CREDITS)) mem_stage_i (
        .clk        (clk),
        .reset      (reset),
        .q_valid    (q_valid),
        .q_uop      (q_uop),
        .out_credit (out_credit),
        .q_take     (q_take),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

// File: rrag_mem_top.f
logic/rrag_mem_pkg.sv
logic/addr_gen.sv
logic/rrag_mem_latch.sv
logic/mem_stage.sv
logic/rrag_mem_top.sv
test/rrag_mem_assert.sv
test/rrag_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=rrag_mem_sim

verilator --binary --timing --assert -Wno-fatal \
    -f rrag_mem_top.f --top-module rrag_mem_tb -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// File: test/rrag_mem_assert.sv
`timescale 1ns/100ps
`default_nettype none

module rrag_mem_assert #(
    parameter int LATCH_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input wire logic                             clk,
    input wire logic                             reset,
    input wire logic                             in_valid,
    input wire logic                             out_credit,
    input wire logic                             out_valid,
    input wire logic [$clog2(LATCH_DEPTH+1)-1:0] credit_return
);

    int up_shadow;  // credits upstream holds.
    int out_shadow; // result credits, charged when the result shows up.

    always_ff @(posedge clk) begin
        if (reset) begin
            up_shadow  <= LATCH_DEPTH;
            out_shadow <= OUT_CREDITS;
        end else begin
            up_shadow  <= up_shadow - int'(in_valid) + int'(credit_return);
            out_shadow <= out_shadow - int'(out_valid) + int'(out_credit);
        end
    end

    issue_needs_credit: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> up_shadow > 0)
        else $error("upstream issued a micro-op while holding no credit");

    result_needs_credit: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_shadow > 0)
        else $error("out_valid fired without a result credit");

    // the cycle after a reset edge must be quiet on every output.
    quiet_in_reset: assert property (@(posedge clk)
        $past(reset) |-> (!out_valid && credit_return == '0))
        else $error("an output was active during reset");

    return_in_range: assert property (@(posedge clk) disable iff (reset)
        int'(credit_return) <= LATCH_DEPTH)
        else $error("credit_return exceeds the latch depth");

endmodule

bind rrag_mem_top rrag_mem_assert #(
    .LATCH_DEPTH (LATCH_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) assert_i (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .out_credit    (out_credit),
    .out_valid     (out_valid),
    .credit_return (credit_return)
);

`default_nettype wire

// File: test/rrag_mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rrag_mem_tb;

    localparam int LATCH_DEPTH = 4;
    localparam int MEM_WORDS   = 64;
    localparam int OUT_CREDITS = 2;
    localparam int MAX_LINES   = 64;
    localparam int CRW         = $clog2(LATCH_DEPTH + 1);
    localparam real PERIOD     = 4.0;

    logic                      clk;
    logic                      reset;
    logic                      flush;
    logic                      in_valid;
    rrag_mem_pkg::rrag_uop_t   in_uop;
    logic [CRW-1:0]            credit_return;
    logic                      out_credit;
    logic                      out_valid;
    rrag_mem_pkg::mem_result_t out_result;

    logic [127:0]            t_name  [MAX_LINES];
    logic [7:0]              t_mode  [MAX_LINES];
    rrag_mem_pkg::rrag_uop_t t_uop   [MAX_LINES];
    logic [31:0]             t_data  [MAX_LINES];
    logic                    t_fault [MAX_LINES];
    realtime                 issue_time [MAX_LINES];
    int                      n_lines;

    int   exp_q[$];       // trace indices of results still owed, oldest first.
    int   up_credits;
    int   issued;
    int   received;
    int   dropped;
    int   flush_pending;
    int   held;           // results whose credit is not yet handed back.
    int   returned_total;
    int   stall_results;
    logic stall;
    int   errors;

    rrag_mem_top #(
        .LATCH_DEPTH (LATCH_DEPTH),
        .MEM_WORDS   (MEM_WORDS),
        .OUT_CREDITS (OUT_CREDITS)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_uop        (in_uop),
        .credit_return (credit_return),
        .out_credit    (out_credit),
        .out_valid     (out_valid),
        .out_result    (out_result)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic load_trace();
        int           fd;
        int           rc;
        string        line;
        logic [127:0] name;
        logic [127:0] mode_s;
        logic [127:0] op_s;
        logic [127:0] size_s;
        logic [31:0]  base;
        logic [31:0]  index;
        logic [31:0]  scale;
        logic [31:0]  disp;
        logic [31:0]  reg_val;
        logic [31:0]  data;
        logic [31:0]  fault;
        fd = $fopen("test/rrag_mem_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open test/rrag_mem_trace.txt");
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 1 && line[0] != "#") begin
                    rc = $sscanf(line, "%s %s %h %h %d %h %s %s %h %h %d", name, mode_s,
                                 base, index, scale, disp, op_s, size_s, reg_val, data, fault);
                    if (rc == 11) begin
                        t_name[n_lines]          = name;
                        t_mode[n_lines]          = mode_s[7:0];
                        t_uop[n_lines].eip       = 32'h1000 + 32'(n_lines * 4);
                        t_uop[n_lines].base      = base;
                        t_uop[n_lines].index     = index;
                        t_uop[n_lines].scale     = scale[1:0];
                        t_uop[n_lines].disp      = disp;
                        t_uop[n_lines].reg_val   = reg_val;
                        t_uop[n_lines].op        = (op_s == "load") ? rrag_mem_pkg::op_load :
                                                   (op_s == "store") ? rrag_mem_pkg::op_store :
                                                   rrag_mem_pkg::op_none;
                        t_uop[n_lines].opsize    = (size_s == "b") ? rrag_mem_pkg::size_byte :
                                                   (size_s == "w") ? rrag_mem_pkg::size_word :
                                                   rrag_mem_pkg::size_dword;
                        t_data[n_lines]          = data;
                        t_fault[n_lines]         = fault[0];
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic send_line(input int idx);
        @(posedge clk);
        in_valid <= 1'b0;
        while (up_credits == 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        in_valid <= 1'b1;
        in_uop   <= t_uop[idx];
        up_credits--;
        issued++;
        issue_time[idx] = $realtime;
        if (t_mode[idx] == "f") begin
            flush_pending++; // never expected back.
        end else begin
            exp_q.push_back(idx);
        end
    endtask

    // returns credits freely until every issued micro-op is accounted for.
    task automatic drain();
        stall <= 1'b0;
        idle_cycles(1);
        while (received + dropped != issued || held != 0) begin
            idle_cycles(1);
        end
        idle_cycles(2);
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        in_valid <= 1'b0;
        flush    <= 1'b1;
        dropped  += flush_pending;
        flush_pending = 0;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic check_credits_home(input string where);
        credits_home: assert (up_credits == LATCH_DEPTH) else begin
            errors++;
            $display("Fail %s upstream credits expected %0d actual %0d",
                     where, LATCH_DEPTH, up_credits);
        end
    endtask

    task automatic check_result(input int idx);
        string nm;
        int    lat;
        nm = $sformatf("%0s", t_name[idx]);
        data_ok: assert (out_result.data === t_data[idx]) else begin
            errors++;
            $display("Fail %s data expected %h actual %h", nm, t_data[idx], out_result.data);
        end
        fault_ok: assert (out_result.fault === t_fault[idx]) else begin
            errors++;
            $display("Fail %s fault expected %b actual %b", nm, t_fault[idx], out_result.fault);
        end
        eip_ok: assert (out_result.eip === t_uop[idx].eip) else begin
            errors++;
            $display("Fail %s eip expected %h actual %h", nm, t_uop[idx].eip, out_result.eip);
        end
        op_ok: assert (out_result.op === t_uop[idx].op) else begin
            errors++;
            $display("Fail %s op expected %0d actual %0d", nm, t_uop[idx].op, out_result.op);
        end
        if (t_mode[idx] == "l") begin
            // out_valid is sampled half a period after the edge that raises it.
            lat = $rtoi(($realtime - issue_time[idx]) / PERIOD);
            latency_ok: assert (lat == 3) else begin
                errors++;
                $display("Fail %s latency expected 3 actual %0d", nm, lat);
            end
        end
    endtask

    always @(negedge clk) begin
        int idx;
        if (!reset) begin
            up_credits     = up_credits + int'(credit_return);
            returned_total = returned_total + int'(credit_return);
            returns_bounded: assert (returned_total <= issued) else begin
                errors++;
                $display("more credits came back (%0d) than micro-ops were issued (%0d)",
                         returned_total, issued);
            end
            if (out_valid) begin
                held++;
                received++;
                if (stall) begin
                    stall_results++;
                    stall_bounded: assert (stall_results <= OUT_CREDITS) else begin
                        errors++;
                        $display("a result appeared with all result credits withheld");
                    end
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("a result appeared with no micro-op pending");
                end else begin
                    idx = exp_q.pop_front();
                    check_result(idx);
                end
            end
        end
    end

    always @(posedge clk) begin
        out_credit <= 1'b0;
        if (!reset && !stall && held > 0 && ($urandom % 3 != 0)) begin
            out_credit <= 1'b1;
            held--;
        end
    end

    initial begin
        wait (n_lines > 0);
        repeat (16 + n_lines * 40) @(posedge clk);
        $display("timeout: the trace did not finish within %0d cycles", n_lines * 40);
        $display("errors: %0d", errors + 1);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [7:0] mode;
        logic [7:0] prev_mode;
        void'($urandom(13825));
        reset          = 1'b1;
        flush          = 1'b0;
        in_valid       = 1'b0;
        in_uop         = '0;
        out_credit     = 1'b0;
        stall          = 1'b0;
        up_credits     = LATCH_DEPTH;
        issued         = 0;
        received       = 0;
        dropped        = 0;
        flush_pending  = 0;
        held           = 0;
        returned_total = 0;
        stall_results  = 0;
        errors         = 0;
        n_lines        = 0;
        load_trace();
        if (n_lines == 0) begin
            errors++;
            $display("no stimulus lines were read from the trace");
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        prev_mode = "n";
        for (int i = 0; i < n_lines; i++) begin
            mode = t_mode[i];
            if (mode != "s" && mode != "f" && prev_mode == "s") begin
                idle_cycles(20); // the stalled entries must stay put meanwhile.
                stall <= 1'b0;
            end
            if (mode == "s" && prev_mode != "s") begin
                drain();
                stall         <= 1'b1;
                stall_results = 0;
            end
            if (mode == "l") begin
                drain();
            end
            send_line(i);
            if (mode == "f" && (i + 1 == n_lines || t_mode[i+1] != "f")) begin
                idle_cycles(4);
                pulse_flush();
                drain();
                check_credits_home("after_flush");
            end
            prev_mode = mode;
        end
        drain();
        check_credits_home("end_of_trace");
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rrag_mem_trace.txt
# name mode base index scale disp op size reg_val exp_data exp_fault
# mode n=normal s=stall results f=flushed l=latency; op load/store/none; size b/w/d
st_s0     n 00000010 00000004 0 00000008 store d 11223344 11223344 0
ld_s0     n 0000001c 00000000 0 00000000 load  d 00000000 11223344 0
st_s1     n 00000020 00000002 1 00000004 store d a5a5a5a5 a5a5a5a5 0
ld_s1     n 00000000 00000014 1 00000000 load  d 00000000 a5a5a5a5 0
st_s2     n 00000040 00000003 2 0000000c store d cafef00d cafef00d 0
ld_s2     n 00000050 00000002 2 00000000 load  d 00000000 cafef00d 0
st_s3     n 00000080 00000002 3 00000010 store d deadbeef deadbeef 0
ld_s3     n 00000000 00000014 3 00000000 load  d 00000000 deadbeef 0
st_neg    n 00000070 00000000 0 fffffff0 store d 01020304 01020304 0
ld_neg    n 00000060 00000000 0 00000000 load  d 00000000 01020304 0
st_b1     n 0000001d 00000000 0 00000000 store b 000000ee 000000ee 0
ld_after_b n 0000001c 00000000 0 00000000 load d 00000000 1122ee44 0
st_w2     n 0000001c 00000001 1 00000000 store w 0000beef 0000beef 0
ld_w2     n 0000001e 00000000 0 00000000 load  w 00000000 0000beef 0
ld_b0     n 0000001c 00000000 0 00000000 load  b 00000000 00000044 0
ld_b3     n 0000001f 00000000 0 00000000 load  b 00000000 000000be 0
ld_w0     n 0000001c 00000000 0 00000000 load  w 00000000 0000ee44 0
st_b_low  n 00000028 00000000 0 00000000 store b ffffff77 ffffff77 0
ld_b_low  n 00000028 00000000 0 00000000 load  d 00000000 a5a5a577 0
fl_cross  n 0000001e 00000000 0 00000000 store d 12345678 00000000 1
fl_crossw n 0000001f 00000000 0 00000000 load  w 00000000 00000000 1
fl_range  n 00000100 00000000 0 00000000 store d 87654321 00000000 1
fl_range2 n 000000fc 00000001 2 00000000 load  b 00000000 00000000 1
ld_kept   n 0000001c 00000000 0 00000000 load  d 00000000 beefee44 0
pass_thru n 000001ff 00000000 0 00000000 none  d 55aa55aa 55aa55aa 0
bp0       s 00000058 00000000 0 00000000 load  d 00000000 cafef00d 0
bp1       s 000000a0 00000000 0 00000000 load  d 00000000 deadbeef 0
bp2       s 00000060 00000000 0 00000000 load  d 00000000 01020304 0
bp3       s 00000060 00000000 0 00000000 store b 000000aa 000000aa 0
bp4       s 00000060 00000000 0 00000000 load  d 00000000 010203aa 0
rel0      n 00000028 00000000 0 00000000 load  b 00000000 00000077 0
fs0       s 0000001c 00000000 0 00000000 load  d 00000000 beefee44 0
fs1       s 00000028 00000000 0 00000000 load  d 00000000 a5a5a577 0
fd0       f 0000001c 00000000 0 00000000 store d 99999999 00000000 0
fd1       f 00000058 00000000 0 00000000 load  d 00000000 00000000 0
fd2       f 00000028 00000000 0 00000000 store d 00000000 00000000 0
fd3       f 00000000 00000000 0 00000000 none  d 0000abcd 00000000 0
chk0      n 0000001c 00000000 0 00000000 load  d 00000000 beefee44 0
chk1      n 00000028 00000000 0 00000000 load  d 00000000 a5a5a577 0
lat0      l 00000000 00000000 0 00000000 none  d 13572468 13572468 0
lat1      l 0000001c 00000000 0 00000000 load  w 00000000 0000ee44 0
lat2      l 00000058 00000000 0 00000000 store d 0badcafe 0badcafe 0
lat3      l 00000058 00000000 0 00000000 load  b 00000000 000000fe 0
